//--- src/be_pkg.sv
package be_pkg;

    // Data path widths
    localparam int xlen       = 32;    // Data and address width
    localparam int reg_addr_w = 5;     // Register file address
    localparam int ecode_w    = 7;     // Exception code, zero is none

    // Branch type reported to the predictor
    localparam int pd_type_w = 2;
    localparam logic [pd_type_w-1:0] pd_none = 2'd0;    // Not a branch

    // Lane-B write-back source select
    localparam int wb_sel_w = 2;
    localparam logic [wb_sel_w-1:0] wb_sel_alu    = 2'd0;    // ALU result
    localparam logic [wb_sel_w-1:0] wb_sel_mul_lo = 2'd1;    // Product bits 31..0
    localparam logic [wb_sel_w-1:0] wb_sel_mul_hi = 2'd2;    // Product bits 63..32
    localparam logic [wb_sel_w-1:0] wb_sel_link   = 2'd3;    // Return address

endpackage

//--- src/ex_mem_reg.sv
`timescale 1ns/1ns

module ex_mem_reg (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            stall_ex,
    input  logic                            stall_dcache,
    input  logic                            flush_csr,

    input  logic                            ex_br_a,         // Lane A mispredicted
    input  logic                            ex_br_b,         // Lane B mispredicted
    input  logic                            ex_br_a_ori,     // Lane A actually taken
    input  logic                            ex_br_b_ori,     // Lane B actually taken
    input  logic                            ex_we_a,
    input  logic                            ex_we_b,
    input  logic [be_pkg::xlen-1:0]         ex_pc_br_a,      // Corrected fetch PC
    input  logic [be_pkg::xlen-1:0]         ex_pc_br_b,
    input  logic [be_pkg::xlen-1:0]         ex_tgt_a,        // Resolved branch target
    input  logic [be_pkg::xlen-1:0]         ex_tgt_b,
    input  logic [be_pkg::xlen-1:0]         ex_pc_a,
    input  logic [be_pkg::xlen-1:0]         ex_pc_b,
    input  logic [be_pkg::xlen-1:0]         ex_alu_result_a,
    input  logic [be_pkg::xlen-1:0]         ex_alu_result_b,
    input  logic [be_pkg::pd_type_w-1:0]    ex_pd_type_a,
    input  logic [be_pkg::pd_type_w-1:0]    ex_pd_type_b,
    input  logic [2*be_pkg::xlen-1:0]       ex_mul_tmp1,     // Partial product
    input  logic [2*be_pkg::xlen-1:0]       ex_mul_tmp2,     // Partial product
    input  logic [be_pkg::reg_addr_w-1:0]   ex_waddr_a,
    input  logic [be_pkg::reg_addr_w-1:0]   ex_waddr_b,
    input  logic [be_pkg::wb_sel_w-1:0]     ex_wb_sel_b,

    output logic                            mem_br,          // Redirect request
    output logic                            mem_br_a,        // Lane A redirect, kills lane B
    output logic [be_pkg::xlen-1:0]         mem_pc_br,       // Redirect PC

    output logic [be_pkg::xlen-1:0]         upd_pc,
    output logic [be_pkg::pd_type_w-1:0]    upd_pd_type,
    output logic [be_pkg::xlen-1:0]         upd_target,
    output logic                            upd_taken,

    output logic                            mem_we_a,
    output logic                            mem_we_b,
    output logic [be_pkg::reg_addr_w-1:0]   mem_waddr_a,
    output logic [be_pkg::reg_addr_w-1:0]   mem_waddr_b,
    output logic [be_pkg::xlen-1:0]         mem_pc_a,
    output logic [be_pkg::xlen-1:0]         mem_pc_b,
    output logic [be_pkg::xlen-1:0]         mem_alu_result_a,
    output logic [be_pkg::xlen-1:0]         mem_alu_result_b,
    output logic [2*be_pkg::xlen-1:0]       mem_mul_tmp1,
    output logic [2*be_pkg::xlen-1:0]       mem_mul_tmp2,
    output logic [be_pkg::wb_sel_w-1:0]     mem_wb_sel_b
);

    logic                           stall;
    logic                           stall_buf;       // Stalled in the previous cycle
    logic                           mem_br_b;
    logic                           mem_we_b_raw;    // Before the lane A kill
    logic [be_pkg::pd_type_w-1:0]   mem_pd_type_a;
    logic [be_pkg::pd_type_w-1:0]   mem_pd_type_b;
    logic                           mem_br_a_ori;
    logic                           mem_br_b_ori;
    logic [be_pkg::xlen-1:0]        mem_pc_br_a;
    logic [be_pkg::xlen-1:0]        mem_pc_br_b;
    logic [be_pkg::xlen-1:0]        mem_tgt_a;
    logic [be_pkg::xlen-1:0]        mem_tgt_b;
    logic                           upd_from_b;      // Lane A is not a branch

    assign stall = stall_ex | stall_dcache;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_buf <= 1'b0;
        end else begin
            stall_buf <= stall;
        end
    end

    // A branch held through a stall only redirects in its first MEM cycle
    assign mem_br    = (mem_br_a | mem_br_b) & ~stall_buf;
    assign mem_pc_br = mem_br_a ? mem_pc_br_a : mem_pc_br_b;
    assign mem_we_b  = mem_we_b_raw & ~mem_br_a;    // Younger lane is on the wrong path

    // Predictor update, older lane first
    assign upd_from_b  = (mem_pd_type_a == be_pkg::pd_none);
    assign upd_pc      = upd_from_b ? mem_pc_b : mem_pc_a;
    assign upd_target  = upd_from_b ? mem_tgt_b : mem_tgt_a;
    assign upd_taken   = upd_from_b ? mem_br_b_ori : mem_br_a_ori;
    assign upd_pd_type = stall_buf ? be_pkg::pd_none
                                   : (upd_from_b ? mem_pd_type_b : mem_pd_type_a);

    // Control bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_we_a      <= 1'b0;
            mem_we_b_raw  <= 1'b0;
            mem_br_a      <= 1'b0;
            mem_br_b      <= 1'b0;
            mem_pd_type_a <= be_pkg::pd_none;
            mem_pd_type_b <= be_pkg::pd_none;
        end else if (flush_csr || mem_br) begin    // Squash the pair coming from EX
            mem_we_a      <= 1'b0;
            mem_we_b_raw  <= 1'b0;
            mem_br_a      <= 1'b0;
            mem_br_b      <= 1'b0;
            mem_pd_type_a <= be_pkg::pd_none;
            mem_pd_type_b <= be_pkg::pd_none;
        end else if (!stall) begin
            mem_we_a      <= ex_we_a;
            mem_we_b_raw  <= ex_we_b;
            mem_br_a      <= ex_br_a;
            mem_br_b      <= ex_br_b;
            mem_pd_type_a <= ex_pd_type_a;
            mem_pd_type_b <= ex_pd_type_b;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_br_a_ori     <= ex_br_a_ori;
            mem_br_b_ori     <= ex_br_b_ori;
            mem_pc_br_a      <= ex_pc_br_a;
            mem_pc_br_b      <= ex_pc_br_b;
            mem_tgt_a        <= ex_tgt_a;
            mem_tgt_b        <= ex_tgt_b;
            mem_pc_a         <= ex_pc_a;
            mem_pc_b         <= ex_pc_b;
            mem_alu_result_a <= ex_alu_result_a;
            mem_alu_result_b <= ex_alu_result_b;
            mem_mul_tmp1     <= ex_mul_tmp1;
            mem_mul_tmp2     <= ex_mul_tmp2;
            mem_waddr_a      <= ex_waddr_a;
            mem_waddr_b      <= ex_waddr_b;
            mem_wb_sel_b     <= ex_wb_sel_b;
        end
    end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
    input  logic [be_pkg::xlen-1:0]      mem_alu_result_b,
    input  logic [2*be_pkg::xlen-1:0]    mem_mul_tmp1,
    input  logic [2*be_pkg::xlen-1:0]    mem_mul_tmp2,
    input  logic [be_pkg::wb_sel_w-1:0]  mem_wb_sel_b,
    input  logic [be_pkg::xlen-1:0]      mem_pc_b,

    output logic [be_pkg::xlen-1:0]      mem_wdata_b
);

    logic [2*be_pkg::xlen-1:0]  product;
    logic [be_pkg::xlen-1:0]    link_addr;

    // Final carry-propagate add of the multiplier array
    assign product   = mem_mul_tmp1 + mem_mul_tmp2;
    assign link_addr = mem_pc_b + be_pkg::xlen'(4);    // Return address for calls

    always_comb begin
        case (mem_wb_sel_b)
            be_pkg::wb_sel_alu: begin
                mem_wdata_b = mem_alu_result_b;
            end
            be_pkg::wb_sel_mul_lo: begin
                mem_wdata_b = product[be_pkg::xlen-1:0];
            end
            be_pkg::wb_sel_mul_hi: begin
                mem_wdata_b = product[2*be_pkg::xlen-1:be_pkg::xlen];
            end
            be_pkg::wb_sel_link: begin
                mem_wdata_b = link_addr;
            end
            default: begin
                mem_wdata_b = mem_alu_result_b;
            end
        endcase
    end

endmodule

//--- src/mem_wb_reg.sv
`timescale 1ns/1ns

module mem_wb_reg (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            stall_ex,
    input  logic                            stall_dcache,
    input  logic                            flush_csr,

    input  logic                            mem_we_a,
    input  logic                            mem_we_b,
    input  logic [be_pkg::reg_addr_w-1:0]   mem_waddr_a,
    input  logic [be_pkg::reg_addr_w-1:0]   mem_waddr_b,
    input  logic [be_pkg::xlen-1:0]         mem_wdata_a,
    input  logic [be_pkg::xlen-1:0]         mem_wdata_b,
    input  logic [be_pkg::xlen-1:0]         mem_pc_a,
    input  logic [be_pkg::xlen-1:0]         mem_pc_b,
    input  logic [be_pkg::ecode_w-1:0]      mem_ecode_a,
    input  logic [be_pkg::ecode_w-1:0]      mem_ecode_b,

    output logic                            wb_we_a,
    output logic                            wb_we_b,
    output logic [be_pkg::reg_addr_w-1:0]   wb_waddr_a,
    output logic [be_pkg::reg_addr_w-1:0]   wb_waddr_b,
    output logic [be_pkg::xlen-1:0]         wb_wdata_a,
    output logic [be_pkg::xlen-1:0]         wb_wdata_b,
    output logic [be_pkg::xlen-1:0]         wb_pc_a,
    output logic [be_pkg::xlen-1:0]         wb_pc_b
);

    logic stall;
    logic exc_a;
    logic exc_b;

    assign stall = stall_ex | stall_dcache;
    assign exc_a = |mem_ecode_a;
    assign exc_b = |mem_ecode_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_a <= 1'b0;
            wb_we_b <= 1'b0;
        end else if (flush_csr) begin
            wb_we_a <= 1'b0;
            wb_we_b <= 1'b0;
        end else if (!stall) begin
            wb_we_a <= mem_we_a & ~exc_a;
            wb_we_b <= mem_we_b & ~exc_a & ~exc_b;    // Older lane fault kills both
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_waddr_a <= mem_waddr_a;
            wb_waddr_b <= mem_waddr_b;
            wb_wdata_a <= mem_wdata_a;
            wb_wdata_b <= mem_wdata_b;
            wb_pc_a    <= mem_pc_a;
            wb_pc_b    <= mem_pc_b;
        end
    end

endmodule

//--- src/be_top.sv
`timescale 1ns/1ns

module be_top (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            stall_ex,
    input  logic                            stall_dcache,
    input  logic                            flush_csr,

    input  logic                            ex_br_a,
    input  logic                            ex_br_b,
    input  logic                            ex_br_a_ori,
    input  logic                            ex_br_b_ori,
    input  logic                            ex_we_a,
    input  logic                            ex_we_b,
    input  logic [be_pkg::xlen-1:0]         ex_pc_br_a,
    input  logic [be_pkg::xlen-1:0]         ex_pc_br_b,
    input  logic [be_pkg::xlen-1:0]         ex_tgt_a,
    input  logic [be_pkg::xlen-1:0]         ex_tgt_b,
    input  logic [be_pkg::xlen-1:0]         ex_pc_a,
    input  logic [be_pkg::xlen-1:0]         ex_pc_b,
    input  logic [be_pkg::xlen-1:0]         ex_alu_result_a,
    input  logic [be_pkg::xlen-1:0]         ex_alu_result_b,
    input  logic [be_pkg::pd_type_w-1:0]    ex_pd_type_a,
    input  logic [be_pkg::pd_type_w-1:0]    ex_pd_type_b,
    input  logic [2*be_pkg::xlen-1:0]       ex_mul_tmp1,
    input  logic [2*be_pkg::xlen-1:0]       ex_mul_tmp2,
    input  logic [be_pkg::reg_addr_w-1:0]   ex_waddr_a,
    input  logic [be_pkg::reg_addr_w-1:0]   ex_waddr_b,
    input  logic [be_pkg::wb_sel_w-1:0]     ex_wb_sel_b,

    input  logic [be_pkg::ecode_w-1:0]      mem_ecode_a,    // Aligned with the MEM pair
    input  logic [be_pkg::ecode_w-1:0]      mem_ecode_b,

    output logic                            mem_br,
    output logic                            mem_br_a,
    output logic [be_pkg::xlen-1:0]         mem_pc_br,
    output logic [be_pkg::xlen-1:0]         upd_pc,
    output logic [be_pkg::pd_type_w-1:0]    upd_pd_type,
    output logic [be_pkg::xlen-1:0]         upd_target,
    output logic                            upd_taken,

    output logic                            wb_we_a,
    output logic                            wb_we_b,
    output logic [be_pkg::reg_addr_w-1:0]   wb_waddr_a,
    output logic [be_pkg::reg_addr_w-1:0]   wb_waddr_b,
    output logic [be_pkg::xlen-1:0]         wb_wdata_a,
    output logic [be_pkg::xlen-1:0]         wb_wdata_b,
    output logic [be_pkg::xlen-1:0]         wb_pc_a,
    output logic [be_pkg::xlen-1:0]         wb_pc_b
);

    logic                           mem_we_a;
    logic                           mem_we_b;
    logic [be_pkg::reg_addr_w-1:0]  mem_waddr_a;
    logic [be_pkg::reg_addr_w-1:0]  mem_waddr_b;
    logic [be_pkg::xlen-1:0]        mem_pc_a;
    logic [be_pkg::xlen-1:0]        mem_pc_b;
    logic [be_pkg::xlen-1:0]        mem_alu_result_a;    // Lane A write data
    logic [be_pkg::xlen-1:0]        mem_alu_result_b;
    logic [2*be_pkg::xlen-1:0]      mem_mul_tmp1;
    logic [2*be_pkg::xlen-1:0]      mem_mul_tmp2;
    logic [be_pkg::wb_sel_w-1:0]    mem_wb_sel_b;
    logic [be_pkg::xlen-1:0]        mem_wdata_b;

    ex_mem_reg u_ex_mem_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall_ex         (stall_ex),
        .stall_dcache     (stall_dcache),
        .flush_csr        (flush_csr),
        .ex_br_a          (ex_br_a),
        .ex_br_b          (ex_br_b),
        .ex_br_a_ori      (ex_br_a_ori),
        .ex_br_b_ori      (ex_br_b_ori),
        .ex_we_a          (ex_we_a),
        .ex_we_b          (ex_we_b),
        .ex_pc_br_a       (ex_pc_br_a),
        .ex_pc_br_b       (ex_pc_br_b),
        .ex_tgt_a         (ex_tgt_a),
        .ex_tgt_b         (ex_tgt_b),
        .ex_pc_a          (ex_pc_a),
        .ex_pc_b          (ex_pc_b),
        .ex_alu_result_a  (ex_alu_result_a),
        .ex_alu_result_b  (ex_alu_result_b),
        .ex_pd_type_a     (ex_pd_type_a),
        .ex_pd_type_b     (ex_pd_type_b),
        .ex_mul_tmp1      (ex_mul_tmp1),
        .ex_mul_tmp2      (ex_mul_tmp2),
        .ex_waddr_a       (ex_waddr_a),
        .ex_waddr_b       (ex_waddr_b),
        .ex_wb_sel_b      (ex_wb_sel_b),
        .mem_br           (mem_br),
        .mem_br_a         (mem_br_a),
        .mem_pc_br        (mem_pc_br),
        .upd_pc           (upd_pc),
        .upd_pd_type      (upd_pd_type),
        .upd_target       (upd_target),
        .upd_taken        (upd_taken),
        .mem_we_a         (mem_we_a),
        .mem_we_b         (mem_we_b),
        .mem_waddr_a      (mem_waddr_a),
        .mem_waddr_b      (mem_waddr_b),
        .mem_pc_a         (mem_pc_a),
        .mem_pc_b         (mem_pc_b),
        .mem_alu_result_a (mem_alu_result_a),
        .mem_alu_result_b (mem_alu_result_b),
        .mem_mul_tmp1     (mem_mul_tmp1),
        .mem_mul_tmp2     (mem_mul_tmp2),
        .mem_wb_sel_b     (mem_wb_sel_b)
    );

    mem_stage u_mem_stage (
        .mem_alu_result_b (mem_alu_result_b),
        .mem_mul_tmp1     (mem_mul_tmp1),
        .mem_mul_tmp2     (mem_mul_tmp2),
        .mem_wb_sel_b     (mem_wb_sel_b),
        .mem_pc_b         (mem_pc_b),
        .mem_wdata_b      (mem_wdata_b)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_ex     (stall_ex),
        .stall_dcache (stall_dcache),
        .flush_csr    (flush_csr),
        .mem_we_a     (mem_we_a),
        .mem_we_b     (mem_we_b),
        .mem_waddr_a  (mem_waddr_a),
        .mem_waddr_b  (mem_waddr_b),
        .mem_wdata_a  (mem_alu_result_a),
        .mem_wdata_b  (mem_wdata_b),
        .mem_pc_a     (mem_pc_a),
        .mem_pc_b     (mem_pc_b),
        .mem_ecode_a  (mem_ecode_a),
        .mem_ecode_b  (mem_ecode_b),
        .wb_we_a      (wb_we_a),
        .wb_we_b      (wb_we_b),
        .wb_waddr_a   (wb_waddr_a),
        .wb_waddr_b   (wb_waddr_b),
        .wb_wdata_a   (wb_wdata_a),
        .wb_wdata_b   (wb_wdata_b),
        .wb_pc_a      (wb_pc_a),
        .wb_pc_b      (wb_pc_b)
    );

endmodule

//--- test/be_sva.sv
`timescale 1ns/1ns

module be_sva (
    input logic clk,
    input logic rst_n,
    input logic flush_csr,
    input logic mem_br,
    input logic mem_br_a,
    input logic mem_we_b,
    input logic wb_we_a,
    input logic wb_we_b
);

    // The redirect squashes the next pair, so it cannot repeat
    no_back_to_back_br: assert property (@(posedge clk) disable iff (!rst_n)
        mem_br |=> !mem_br)
        else $error("mem_br high on two consecutive cycles");

    br_a_kills_we_b: assert property (@(posedge clk) disable iff (!rst_n)
        mem_br_a |-> !mem_we_b)
        else $error("lane B write enabled under a lane A redirect");

    flush_clears_we: assert property (@(posedge clk) disable iff (!rst_n)
        flush_csr |=> (!wb_we_a && !wb_we_b))
        else $error("write enable set in the cycle after flush_csr");

endmodule

// MEM write enables stand in for the WB ones on the first register
bind ex_mem_reg be_sva u_ex_mem_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_csr (flush_csr),
    .mem_br    (mem_br),
    .mem_br_a  (mem_br_a),
    .mem_we_b  (mem_we_b),
    .wb_we_a   (mem_we_a),
    .wb_we_b   (mem_we_b)
);

bind mem_wb_reg be_sva u_mem_wb_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_csr (flush_csr),
    .mem_br    (1'b0),
    .mem_br_a  (1'b0),
    .mem_we_b  (mem_we_b),
    .wb_we_a   (wb_we_a),
    .wb_we_b   (wb_we_b)
);

//--- test/tb_be.sv
`timescale 1ns/1ns

module tb_be;

    localparam int num_cycles = 2000;
    localparam int clk_period = 10;

    logic clk, rst_n, stall_ex, stall_dcache, flush_csr;
    logic ex_br_a, ex_br_b, ex_br_a_ori, ex_br_b_ori, ex_we_a, ex_we_b;
    logic [be_pkg::xlen-1:0] ex_pc_br_a, ex_pc_br_b, ex_tgt_a, ex_tgt_b, ex_pc_a, ex_pc_b;
    logic [be_pkg::xlen-1:0] ex_alu_result_a, ex_alu_result_b;
    logic [2*be_pkg::xlen-1:0] ex_mul_tmp1, ex_mul_tmp2;
    logic [be_pkg::pd_type_w-1:0] ex_pd_type_a, ex_pd_type_b, upd_pd_type;
    logic [be_pkg::reg_addr_w-1:0] ex_waddr_a, ex_waddr_b, wb_waddr_a, wb_waddr_b;
    logic [be_pkg::wb_sel_w-1:0] ex_wb_sel_b;
    logic [be_pkg::ecode_w-1:0] mem_ecode_a, mem_ecode_b;
    logic mem_br, mem_br_a, upd_taken, wb_we_a, wb_we_b;
    logic [be_pkg::xlen-1:0] mem_pc_br, upd_pc, upd_target;
    logic [be_pkg::xlen-1:0] wb_wdata_a, wb_wdata_b, wb_pc_a, wb_pc_b;

    // Model of the EX->MEM register and its stall buffer
    logic m_stall_buf, m_we_a, m_we_b, m_br_a, m_br_b, m_ori_a, m_ori_b;
    logic [be_pkg::pd_type_w-1:0] m_pdt_a, m_pdt_b;
    logic [be_pkg::xlen-1:0] m_pcbr_a, m_pcbr_b, m_tgt_a, m_tgt_b;
    logic [be_pkg::xlen-1:0] m_pc_a, m_pc_b, m_alu_a, m_alu_b;
    logic [2*be_pkg::xlen-1:0] m_tmp1, m_tmp2;
    logic [be_pkg::reg_addr_w-1:0] m_waddr_a, m_waddr_b;
    logic [be_pkg::wb_sel_w-1:0] m_sel_b;
    // Model of the MEM->WB register
    logic m_wb_we_a, m_wb_we_b;
    logic [be_pkg::reg_addr_w-1:0] m_wb_waddr_a, m_wb_waddr_b;
    logic [be_pkg::xlen-1:0] m_wb_wdata_a, m_wb_wdata_b, m_wb_pc_a, m_wb_pc_b;

    logic exp_br, exp_we_b, exp_upd_b, exp_upd_taken;
    logic [be_pkg::pd_type_w-1:0] exp_upd_type;
    logic [be_pkg::xlen-1:0] exp_pc_br, exp_upd_pc, exp_upd_tgt, exp_wdata_b;
    logic [2*be_pkg::xlen-1:0] exp_product;

    integer seed = 32'h4f74_6da2;
    int errors = 0;
    int cycles_checked = 0;

    be_top DUT (.*);

    always #(clk_period/2) clk = ~clk;

    assign exp_br        = (m_br_a | m_br_b) & ~m_stall_buf;    // One redirect per branch
    assign exp_pc_br     = m_br_a ? m_pcbr_a : m_pcbr_b;
    assign exp_we_b      = m_we_b & ~m_br_a;                    // Lane B on the wrong path
    assign exp_upd_b     = (m_pdt_a == be_pkg::pd_none);        // Older lane first
    assign exp_upd_type  = m_stall_buf ? be_pkg::pd_none : (exp_upd_b ? m_pdt_b : m_pdt_a);
    assign exp_upd_pc    = exp_upd_b ? m_pc_b : m_pc_a;
    assign exp_upd_tgt   = exp_upd_b ? m_tgt_b : m_tgt_a;
    assign exp_upd_taken = exp_upd_b ? m_ori_b : m_ori_a;
    assign exp_product   = m_tmp1 + m_tmp2;
    assign exp_wdata_b   = (m_sel_b == be_pkg::wb_sel_mul_lo) ? exp_product[31:0]
                         : (m_sel_b == be_pkg::wb_sel_mul_hi) ? exp_product[63:32]
                         : (m_sel_b == be_pkg::wb_sel_link)   ? m_pc_b + 32'd4
                         : m_alu_b;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        errors++;
        $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, expected);
    endtask

    // Sparse stalls, branches, exceptions and flushes
    task automatic drive_random_pair();
        stall_ex     = ({$random(seed)} % 10) == 0;
        stall_dcache = ({$random(seed)} % 12) == 0;
        flush_csr    = ({$random(seed)} % 50) == 0;
        ex_br_a      = ({$random(seed)} % 8) == 0;
        ex_br_b      = ({$random(seed)} % 8) == 0;
        ex_we_a      = ({$random(seed)} % 4) != 0;
        ex_we_b      = ({$random(seed)} % 4) != 0;
        {ex_br_a_ori, ex_br_b_ori} = $random(seed);
        ex_pd_type_a = ({$random(seed)} % 2) ? $random(seed) : be_pkg::pd_none;
        ex_pd_type_b = ({$random(seed)} % 2) ? $random(seed) : be_pkg::pd_none;
        ex_pc_a      = {$random(seed)} & ~32'd3;    // Word aligned pair
        ex_pc_b      = ex_pc_a + 32'd4;
        {ex_pc_br_a, ex_pc_br_b} = {$random(seed), $random(seed)};
        {ex_tgt_a, ex_tgt_b} = {$random(seed), $random(seed)};
        {ex_alu_result_a, ex_alu_result_b} = {$random(seed), $random(seed)};
        ex_mul_tmp1  = {$random(seed), $random(seed)};
        ex_mul_tmp2  = {$random(seed), $random(seed)};
        {ex_waddr_a, ex_waddr_b, ex_wb_sel_b} = $random(seed);
        mem_ecode_a  = ({$random(seed)} % 16 == 0) ? $random(seed) : 0;
        mem_ecode_b  = ({$random(seed)} % 16 == 0) ? $random(seed) : 0;
    endtask

    // Same edge as the DUT, next state from current state
    always @(posedge clk) begin : model_step
        logic stall;
        stall = stall_ex | stall_dcache;
        if (!rst_n || flush_csr) begin
            {m_wb_we_a, m_wb_we_b} = 2'b00;
        end else if (!stall) begin
            m_wb_we_a = m_we_a & (mem_ecode_a == 0);
            m_wb_we_b = exp_we_b & (mem_ecode_a == 0) & (mem_ecode_b == 0);
        end
        if (!stall) begin
            {m_wb_waddr_a, m_wb_waddr_b} = {m_waddr_a, m_waddr_b};
            {m_wb_wdata_a, m_wb_wdata_b} = {m_alu_a, exp_wdata_b};
            {m_wb_pc_a, m_wb_pc_b} = {m_pc_a, m_pc_b};
        end
        if (!rst_n || flush_csr || exp_br) begin    // Squash of the pair leaving EX
            {m_we_a, m_we_b, m_br_a, m_br_b} = 4'b0000;
            {m_pdt_a, m_pdt_b} = {be_pkg::pd_none, be_pkg::pd_none};
        end else if (!stall) begin
            {m_we_a, m_we_b, m_br_a, m_br_b} = {ex_we_a, ex_we_b, ex_br_a, ex_br_b};
            {m_pdt_a, m_pdt_b} = {ex_pd_type_a, ex_pd_type_b};
        end
        if (!stall) begin
            {m_ori_a, m_ori_b, m_sel_b} = {ex_br_a_ori, ex_br_b_ori, ex_wb_sel_b};
            {m_pcbr_a, m_pcbr_b} = {ex_pc_br_a, ex_pc_br_b};
            {m_tgt_a, m_tgt_b, m_pc_a, m_pc_b} = {ex_tgt_a, ex_tgt_b, ex_pc_a, ex_pc_b};
            {m_alu_a, m_alu_b} = {ex_alu_result_a, ex_alu_result_b};
            {m_tmp1, m_tmp2} = {ex_mul_tmp1, ex_mul_tmp2};
            {m_waddr_a, m_waddr_b} = {ex_waddr_a, ex_waddr_b};
        end
        m_stall_buf = rst_n & stall;
    end

    // All checked outputs come from register state, settled by the falling edge
    always @(negedge clk) begin
        cycles_checked++;
        if (mem_br !== exp_br) report_mismatch("mem_br", mem_br, exp_br);
        if (mem_br_a !== m_br_a) report_mismatch("mem_br_a", mem_br_a, m_br_a);
        if (mem_pc_br !== exp_pc_br) report_mismatch("mem_pc_br", mem_pc_br, exp_pc_br);
        if (upd_pd_type !== exp_upd_type)
            report_mismatch("upd_pd_type", upd_pd_type, exp_upd_type);
        if (upd_pc !== exp_upd_pc) report_mismatch("upd_pc", upd_pc, exp_upd_pc);
        if (upd_target !== exp_upd_tgt) report_mismatch("upd_target", upd_target, exp_upd_tgt);
        if (upd_taken !== exp_upd_taken) report_mismatch("upd_taken", upd_taken, exp_upd_taken);
        if (wb_we_a !== m_wb_we_a) report_mismatch("wb_we_a", wb_we_a, m_wb_we_a);
        if (wb_we_b !== m_wb_we_b) report_mismatch("wb_we_b", wb_we_b, m_wb_we_b);
        if (wb_waddr_a !== m_wb_waddr_a) report_mismatch("wb_waddr_a", wb_waddr_a, m_wb_waddr_a);
        if (wb_waddr_b !== m_wb_waddr_b) report_mismatch("wb_waddr_b", wb_waddr_b, m_wb_waddr_b);
        if (wb_wdata_a !== m_wb_wdata_a) report_mismatch("wb_wdata_a", wb_wdata_a, m_wb_wdata_a);
        if (wb_wdata_b !== m_wb_wdata_b) report_mismatch("wb_wdata_b", wb_wdata_b, m_wb_wdata_b);
        if (wb_pc_a !== m_wb_pc_a) report_mismatch("wb_pc_a", wb_pc_a, m_wb_pc_a);
        if (wb_pc_b !== m_wb_pc_b) report_mismatch("wb_pc_b", wb_pc_b, m_wb_pc_b);
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        drive_random_pair();
        {stall_ex, stall_dcache, flush_csr} = 3'b000;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (num_cycles) begin
            @(posedge clk);
            #1 drive_random_pair();
        end
        @(posedge clk);
        #1;
        $display("Cycles checked: %0d, errors: %0d", cycles_checked, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Random run plus reset and a 50 cycle margin
    initial begin
        #((num_cycles + 50) * clk_period);
        $display("Timeout: the random run did not end within %0d cycles", num_cycles + 50);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- build.f
src/be_pkg.sv
src/ex_mem_reg.sv
src/mem_stage.sv
src/mem_wb_reg.sv
src/be_top.sv
test/be_sva.sv
test/tb_be.sv
